//--- rvPipeCore.f
+incdir+verilog
verilog/rvPipePkg.sv
verilog/issueStage.sv
verilog/hazardUnit.sv
verilog/regFile.sv
verilog/executeUnit.sv
verilog/memWbStage.sv
verilog/rvPipeCore.sv
verification/rvPipeCore_checker.sv
verification/rvPipeCore_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rvPipeCore_tb
FILELIST  ?= rvPipeCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/rvPipeCore_tb.sv
`default_nettype none
`include "rvPipeCore_defines.svh"

module rvPipeCore_tb;
    localparam int WATCHDOG_CYCLES = 184 + 5 * 16 + 100;   // Programs, resets, margin

    logic CLK, rst;
    logic [`XLEN-1:0]    instr, ramRData, ramWData, gpio, goldGpio;
    logic [`IADDR_W-1:0] instrAddr;
    logic [`DADDR_W-1:0] ramAddr;
    logic                ramWe;
    logic [`XLEN-1:0]    rom [0:1023];
    logic [`XLEN-1:0]    ram [0:1023];
    logic [`XLEN-1:0]    goldRam [0:1023];
    logic [`XLEN-1:0]    gold [0:31];
    logic [`XLEN-1:0]    gpioExp [$];
    logic [`XLEN-1:0]    gpioSeen [$];
    int pc, errors, checks, holds;

    rvPipeCore rvPipeCore_inst (.*);

    assign instr    = rom[instrAddr];   // Same-cycle ROM and RAM reads
    assign ramRData = ram[ramAddr];

    always @(posedge CLK) begin
        if (ramWe)
            ram[ramAddr] <= ramWData;
    end

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_CYCLES * 40);
        $display("Timeout, the run did not finish in time");
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic putInstr(input logic [31:0] w);
        rom[pc] = w;
        pc++;
    endtask

    task automatic regOp(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        putInstr({1'b0, alt, 5'b0, rs2, rs1, f3, rd, `OP_REG});
        if (rd != 0) gold[rd] = refAlu(f3, alt, gold[rs1], gold[rs2]);
    endtask

    task automatic immOp(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
        putInstr({imm, rs1, f3, rd, `OP_IMM});
        if (rd != 0) gold[rd] = refAlu(f3, f3 == 3'd5 && imm[10], gold[rs1], 32'($signed(imm)));
    endtask

    task automatic loadUpper(input logic [4:0] rd, input logic [19:0] imm);
        putInstr({imm, rd, `OP_LUI});
        if (rd != 0) gold[rd] = {imm, 12'b0};
    endtask

    task automatic storeWord(input logic [4:0] rs2, input logic [4:0] rs1,
                             input logic [11:0] imm);
        logic [31:0] addr;
        addr = gold[rs1] + 32'($signed(imm));
        putInstr({imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE});
        if (addr[11:2] == `GPIO_ADDR) begin
            if (gold[rs2] !== goldGpio)
                gpioExp.push_back(gold[rs2]);   // Only changes show on the port
            goldGpio = gold[rs2];
        end
        else
            goldRam[addr[11:2]] = gold[rs2];
    endtask

    task automatic loadWord(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = gold[rs1] + 32'($signed(imm));
        putInstr({imm, rs1, 3'b010, rd, `OP_LOAD});
        if (rd != 0) gold[rd] = goldRam[addr[11:2]];
    endtask

    // The lui part absorbs the sign of the low half
    task automatic setReg(input logic [4:0] rd, input logic [31:0] v);
        loadUpper(rd, v[31:12] + 20'(v[11]));
        immOp(3'd0, rd, rd, v[11:0]);
    endtask

    task automatic startProgram;
        @(posedge CLK);
        rst <= 1'b1;
        pc = 0;
        for (int i = 0; i < 1024; i++) rom[i] = `NOP_INSTR;
        goldGpio = '0;
        gpioExp.delete();
        gpioSeen.delete();
    endtask

    task automatic runProgram;
        logic [`IADDR_W-1:0] prev;
        logic [`XLEN-1:0]    prevGpio;
        repeat (4) @(posedge CLK);
        rst <= 1'b0;
        holds = 0;
        @(negedge CLK);
        prev = instrAddr;
        prevGpio = gpio;
        repeat (pc + 10) begin
            @(negedge CLK);
            if (instrAddr == prev) holds++;
            prev = instrAddr;
            if (gpio !== prevGpio) gpioSeen.push_back(gpio);
            prevGpio = gpio;
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkRam;
        for (int i = 0; i < 1024; i++) checkValue($sformatf("ram[%0d]", i), ram[i], goldRam[i]);
    endtask

    task automatic checkGpioTrace;
        checkValue("gpio update count", 32'(gpioSeen.size()), 32'(gpioExp.size()));
        for (int i = 0; i < gpioExp.size() && i < gpioSeen.size(); i++)
            checkValue($sformatf("gpio update %0d", i), gpioSeen[i], gpioExp[i]);
    endtask

    task automatic resetState;
        startProgram();
        repeat (3) @(posedge CLK);
        rst <= 1'b0;
        @(negedge CLK);
        checkValue("gpio", gpio, '0);
        checkValue("ramWe", 32'(ramWe), '0);
        checkValue("instrAddr", 32'(instrAddr), '0);
    endtask

    task automatic aluChain;
        logic [2:0]  f3R  [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        logic [2:0]  f3I  [8]  = '{2, 3, 4, 6, 7, 1, 5, 5};
        logic [11:0] immI [8]  = '{12'h8a5, 12'h7f0, 12'h5c3, 12'h0f0, 12'hf3c, 12'h003,
                                   12'h007, 12'h405};
        startProgram();
        immOp(3'd0, 1, 0, 12'h123);
        immOp(3'd0, 2, 1, 12'hffb);
        for (int k = 0; k < 10; k++) begin
            regOp(f3R[k], k == 1 || k == 7, 5'(3 + k), 5'(2 + k), 5'(1 + k));
            storeWord(5'(3 + k), 0, 12'h000);
        end
        for (int k = 0; k < 8; k++) begin
            immOp(f3I[k], 5'(13 + k), 5'(12 + k), immI[k]);
            storeWord(5'(13 + k), 0, 12'h000);
        end
        runProgram();
        checkValue("gpio", gpio, goldGpio);
        checkGpioTrace();
    endtask

    task automatic constantStores;
        startProgram();
        setReg(8, 32'h1234_5678);
        setReg(9, 32'hfedc_ba98);
        storeWord(8, 0, 12'h008);
        storeWord(9, 0, 12'h00c);
        storeWord(9, 0, 12'h000);
        runProgram();
        checkValue("gpio", gpio, goldGpio);
        checkRam();
    endtask

    task automatic loadUseStall;
        startProgram();
        setReg(5, 32'h0000_0abc);
        storeWord(5, 0, 12'h040);
        loadWord(6, 0, 12'h040);
        regOp(3'd0, 1'b0, 7, 6, 5);
        storeWord(7, 0, 12'h000);
        runProgram();
        checkValue("gpio", gpio, goldGpio);
        checkValue("stall count", 32'(holds), 32'd1);
    endtask

    task automatic randomProgram;
        logic [2:0]  f3;
        logic [11:0] imm;
        startProgram();
        for (int r = 1; r < 32; r++) setReg(5'(r), $urandom);
        repeat (40) begin
            f3  = 3'($urandom);
            imm = 12'($urandom);
            case ($urandom % 3)
                0: regOp(f3, (f3 == 0 || f3 == 5) && 1'($urandom), 5'(1 + $urandom % 31),
                         5'($urandom), 5'($urandom));
                1: begin
                    if (f3 == 3'd1) imm = {7'b0, imm[4:0]};
                    if (f3 == 3'd5) imm = {1'b0, imm[10], 5'b0, imm[4:0]};
                    immOp(f3, 5'(1 + $urandom % 31), 5'($urandom), imm);
                end
                default: loadUpper(5'(1 + $urandom % 31), 20'($urandom));
            endcase
        end
        for (int r = 1; r < 32; r++) storeWord(5'(r), 0, 12'(256 + 4 * r));
        runProgram();
        checkRam();
    endtask

    initial begin
        void'($urandom(92755));
        rst = 1'b1;
        gold[0] = '0;
        for (int i = 0; i < 1024; i++) begin
            rom[i]     = `NOP_INSTR;
            ram[i]     = {16'hc0de, 6'b0, 10'(i)};  // Address-tagged fill
            goldRam[i] = ram[i];
        end
        resetState();
        aluChain();
        constantStores();
        loadUseStall();
        randomProgram();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/rvPipeCore_checker.sv
`default_nettype none
`include "rvPipeCore_defines.svh"

module rvPipeCore_checker (
    input wire logic                CLK,
    input wire logic                rst,
    input wire logic                ramWe,
    input wire logic [`IADDR_W-1:0] instrAddr
);
    // Bubbles only after reset, so no store can be in flight
    assert property (@(posedge CLK) rst |=> !ramWe)
        else $error("ramWe high in the cycle after reset");

    assert property (@(posedge CLK) disable iff (rst)
        !$past(rst) |-> (instrAddr == $past(instrAddr) + 1'b1 || instrAddr == $past(instrAddr)))
        else $error("instrAddr neither advanced by one nor held");

    // A load-use stall lasts exactly one cycle
    assert property (@(posedge CLK) disable iff (rst)
        (!$past(rst) && instrAddr == $past(instrAddr)) |=> instrAddr != $past(instrAddr))
        else $error("instrAddr held for two cycles in a row");

endmodule

bind rvPipeCore rvPipeCore_checker rvPipeCore_checker_inst (
    .CLK(CLK), .rst(rst), .ramWe(ramWe), .instrAddr(instrAddr)
);

`default_nettype wire

//--- verilog/rvPipeCore.sv
`default_nettype none
`include "rvPipeCore_defines.svh"

module rvPipeCore import rvPipePkg::*; (
    input  logic                CLK,
    input  logic                rst,
    input  logic [`XLEN-1:0]    instr,
    output logic [`IADDR_W-1:0] instrAddr,
    output logic [`DADDR_W-1:0] ramAddr,
    output logic [`XLEN-1:0]    ramWData,
    output logic                ramWe,
    input  logic [`XLEN-1:0]    ramRData,
    output logic [`XLEN-1:0]    gpio
);
    instrWord                decodeInstr;
    instrWord                execInstr;
    logic                    loadStall;
    logic [1:0]              fwdA;
    logic [1:0]              fwdB;
    logic [`XLEN-1:0]        rData1;
    logic [`XLEN-1:0]        rData2;
    logic [`XLEN-1:0]        aluResult;
    logic [`XLEN-1:0]        storeData;
    logic [`REG_AW-1:0]      memRd;
    logic                    memWrites;
    logic                    memIsLoad;
    logic [`XLEN-1:0]        memResult;
    logic [`REG_AW-1:0]      wbRd;
    logic                    wbWe;
    logic [`XLEN-1:0]        wbData;

    issueStage issueStage_inst (
        .CLK(CLK), .rst(rst), .instr(instr), .loadStall(loadStall),
        .instrAddr(instrAddr), .decodeInstr(decodeInstr), .execInstr(execInstr)
    );

    hazardUnit hazardUnit_inst (
        .decodeInstr(decodeInstr), .execInstr(execInstr), .memRd(memRd), .wbRd(wbRd),
        .memWrites(memWrites), .memIsLoad(memIsLoad), .wbWe(wbWe),
        .loadStall(loadStall), .fwdA(fwdA), .fwdB(fwdB)
    );

    // Operands are read in execute, writeback data lands on the same edge
    regFile regFile_inst (
        .CLK(CLK), .rs1(execInstr.rFields.rs1), .rs2(execInstr.rFields.rs2),
        .rd(wbRd), .we(wbWe), .wData(wbData), .rData1(rData1), .rData2(rData2)
    );

    executeUnit executeUnit_inst (
        .execInstr(execInstr), .rData1(rData1), .rData2(rData2),
        .memResult(memResult), .wbData(wbData), .fwdA(fwdA), .fwdB(fwdB),
        .aluResult(aluResult), .storeData(storeData)
    );

    memWbStage memWbStage_inst (
        .CLK(CLK), .rst(rst), .execInstr(execInstr), .aluResult(aluResult),
        .storeData(storeData), .ramRData(ramRData), .ramAddr(ramAddr),
        .ramWData(ramWData), .ramWe(ramWe), .gpio(gpio), .memRd(memRd),
        .memWrites(memWrites), .memIsLoad(memIsLoad), .memResult(memResult),
        .wbRd(wbRd), .wbWe(wbWe), .wbData(wbData)
    );

endmodule

`default_nettype wire

//--- verilog/memWbStage.sv
`default_nettype none
`include "rvPipeCore_defines.svh"

module memWbStage import rvPipePkg::*; (
    input  logic                CLK,
    input  logic                rst,
    input  instrWord            execInstr,
    input  logic [`XLEN-1:0]    aluResult,
    input  logic [`XLEN-1:0]    storeData,
    input  logic [`XLEN-1:0]    ramRData,
    output logic [`DADDR_W-1:0] ramAddr,
    output logic [`XLEN-1:0]    ramWData,
    output logic                ramWe,
    output logic [`XLEN-1:0]    gpio,
    output logic [`REG_AW-1:0]  memRd,
    output logic                memWrites,
    output logic                memIsLoad,
    output logic [`XLEN-1:0]    memResult,
    output logic [`REG_AW-1:0]  wbRd,
    output logic                wbWe,
    output logic [`XLEN-1:0]    wbData
);
    instrWord         memInstr;
    logic [`XLEN-1:0] memStore;
    logic             memIsStore;
    logic             gpioHit;

    always_ff @(posedge CLK) begin
        if (rst)
            memInstr <= `NOP_INSTR;
        else
            memInstr <= execInstr;
        memResult <= aluResult;
        memStore  <= storeData;
    end

    assign memRd      = memInstr.rFields.rd;
    assign memIsLoad  = memInstr.rFields.opcode == `OP_LOAD;
    assign memIsStore = memInstr.rFields.opcode == `OP_STORE;
    // Unknown opcodes never write, which makes them no-ops
    assign memWrites  = memInstr.rFields.opcode inside {`OP_REG, `OP_IMM, `OP_LOAD, `OP_LUI} &&
                        memRd != '0;

    assign ramAddr  = memResult[`DADDR_W+1:2];  // Byte address to word address
    assign ramWData = memStore;
    assign gpioHit  = ramAddr == `GPIO_ADDR;
    assign ramWe    = memIsStore && !gpioHit;

    always_ff @(posedge CLK) begin
        if (rst) begin
            gpio <= '0;
            wbWe <= 1'b0;
        end
        else begin
            if (memIsStore && gpioHit)
                gpio <= memStore;
            wbWe <= memWrites;
        end
        wbRd   <= memRd;
        wbData <= memIsLoad ? ramRData : memResult;
    end

endmodule

`default_nettype wire

//--- verilog/executeUnit.sv
`default_nettype none
`include "rvPipeCore_defines.svh"

module executeUnit import rvPipePkg::*; (
    input  instrWord         execInstr,
    input  logic [`XLEN-1:0] rData1,
    input  logic [`XLEN-1:0] rData2,
    input  logic [`XLEN-1:0] memResult,
    input  logic [`XLEN-1:0] wbData,
    input  logic [1:0]       fwdA,
    input  logic [1:0]       fwdB,
    output logic [`XLEN-1:0] aluResult,
    output logic [`XLEN-1:0] storeData
);
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immU;
    logic [`XLEN-1:0] aluB;
    logic [4:0]       shamt;
    aluOp             opSel;

    function automatic logic [`XLEN-1:0] fwdMux(input logic [1:0] sel,
                                                input logic [`XLEN-1:0] rf,
                                                input logic [`XLEN-1:0] mem,
                                                input logic [`XLEN-1:0] wb);
        case (sel)
            `FWD_MEM: return mem;
            `FWD_WB:  return wb;
            default:  return rf;
        endcase
    endfunction

    // alt is funct7 bit 5, picks sub and sra
    function automatic aluOp decodeOp(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'd0:    return alt ? aluSub : aluAdd;
            3'd1:    return aluSll;
            3'd2:    return aluSlt;
            3'd3:    return aluSltu;
            3'd4:    return aluXor;
            3'd5:    return alt ? aluSra : aluSrl;
            3'd6:    return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    assign opA       = fwdMux(fwdA, rData1, memResult, wbData);
    assign opB       = fwdMux(fwdB, rData2, memResult, wbData);
    assign storeData = opB;

    assign immI = {{20{execInstr.rFields.funct7[6]}}, execInstr.rFields.funct7,
                   execInstr.rFields.rs2};
    assign immS = {{20{execInstr.sFields.immHigh[6]}}, execInstr.sFields.immHigh,
                   execInstr.sFields.immLow};
    assign immU = {execInstr.rFields.funct7, execInstr.rFields.rs2, execInstr.rFields.rs1,
                   execInstr.rFields.funct3, 12'b0};

    always_comb begin
        case (execInstr.rFields.opcode)
            `OP_REG: begin
                opSel = decodeOp(execInstr.rFields.funct3, execInstr.rFields.funct7[5]);
                aluB  = opB;
            end
            `OP_IMM: begin
                // Only srai carries the alt bit, addi has no subtract form
                opSel = decodeOp(execInstr.rFields.funct3,
                                 execInstr.rFields.funct3 == 3'd5 && execInstr.rFields.funct7[5]);
                aluB  = immI;
            end
            `OP_STORE: begin
                opSel = aluAdd;
                aluB  = immS;
            end
            `OP_LUI: begin
                opSel = aluPassB;
                aluB  = immU;
            end
            default: begin
                opSel = aluAdd;     // Load address
                aluB  = immI;
            end
        endcase
    end

    assign shamt = aluB[4:0];

    always_comb begin
        case (opSel)
            aluAdd:  aluResult = opA + aluB;
            aluSub:  aluResult = opA - aluB;
            aluSll:  aluResult = opA << shamt;
            aluSlt:  aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
            aluSltu: aluResult = {{(`XLEN-1){1'b0}}, opA < aluB};
            aluXor:  aluResult = opA ^ aluB;
            aluSrl:  aluResult = opA >> shamt;
            aluSra:  aluResult = `XLEN'($signed(opA) >>> shamt);
            aluOr:   aluResult = opA | aluB;
            aluAnd:  aluResult = opA & aluB;
            default: aluResult = aluB;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`default_nettype none
`include "rvPipeCore_defines.svh"

module regFile (
    input  logic               CLK,
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    input  logic [`REG_AW-1:0] rd,
    input  logic               we,
    input  logic [`XLEN-1:0]   wData,
    output logic [`XLEN-1:0]   rData1,
    output logic [`XLEN-1:0]   rData2
);
    logic [`XLEN-1:0] regs [0:(1 << `REG_AW)-1];

    always_ff @(posedge CLK) begin
        if (we && rd != '0)     // x0 stays zero
            regs[rd] <= wData;
    end

    // Old value while a write is pending, writeback forwarding covers it
    assign rData1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`default_nettype none
`include "rvPipeCore_defines.svh"

module hazardUnit import rvPipePkg::*; (
    input  instrWord           decodeInstr,
    input  instrWord           execInstr,
    input  logic [`REG_AW-1:0] memRd,
    input  logic [`REG_AW-1:0] wbRd,
    input  logic               memWrites,
    input  logic               memIsLoad,
    input  logic               wbWe,
    output logic               loadStall,
    output logic [1:0]         fwdA,
    output logic [1:0]         fwdB
);
    function automatic logic usesRs1(input instrWord i);
        return i.rFields.opcode inside {`OP_REG, `OP_IMM, `OP_LOAD, `OP_STORE};
    endfunction

    function automatic logic usesRs2(input instrWord i);
        return i.rFields.opcode inside {`OP_REG, `OP_STORE};
    endfunction

    // Memory stage has priority, it holds the younger result
    function automatic logic [1:0] fwdSel(input logic used, input logic [`REG_AW-1:0] rs,
                                          input logic [`REG_AW-1:0] mRd, input logic mW,
                                          input logic mLoad, input logic [`REG_AW-1:0] wRd,
                                          input logic wW);
        if (!used || rs == '0)
            return `FWD_RF;
        if (mW && !mLoad && mRd == rs)
            return `FWD_MEM;
        if (wW && wRd == rs)
            return `FWD_WB;
        return `FWD_RF;
    endfunction

    assign fwdA = fwdSel(usesRs1(execInstr), execInstr.rFields.rs1,
                         memRd, memWrites, memIsLoad, wbRd, wbWe);
    assign fwdB = fwdSel(usesRs2(execInstr), execInstr.rFields.rs2,
                         memRd, memWrites, memIsLoad, wbRd, wbWe);

    // Load result only exists after the memory stage
    assign loadStall = execInstr.rFields.opcode == `OP_LOAD && execInstr.rFields.rd != '0 &&
        ((usesRs1(decodeInstr) && decodeInstr.rFields.rs1 == execInstr.rFields.rd) ||
         (usesRs2(decodeInstr) && decodeInstr.rFields.rs2 == execInstr.rFields.rd));

endmodule

`default_nettype wire

//--- verilog/issueStage.sv
`default_nettype none
`include "rvPipeCore_defines.svh"

module issueStage import rvPipePkg::*; (
    input  logic                CLK,
    input  logic                rst,
    input  logic [`XLEN-1:0]    instr,
    input  logic                loadStall,
    output logic [`IADDR_W-1:0] instrAddr,
    output instrWord            decodeInstr,
    output instrWord            execInstr
);
    // instrAddr is the PC itself, counted in words
    always_ff @(posedge CLK) begin
        if (rst) begin
            instrAddr   <= '0;
            decodeInstr <= `NOP_INSTR;
            execInstr   <= `NOP_INSTR;
        end
        else if (loadStall) begin
            // PC and decode hold, execute gets a bubble
            execInstr <= `NOP_INSTR;
        end
        else begin
            instrAddr   <= instrAddr + 1'b1;
            decodeInstr <= instr;           // ROM answers in the same cycle
            execInstr   <= decodeInstr;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rvPipePkg.sv
`default_nettype none
`include "rvPipeCore_defines.svh"

package rvPipePkg;

    // R layout, the I and U immediates are cut from the same fields
    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } rFieldsT;

    // S layout, immLow sits where rd is for everything else
    typedef struct packed {
        logic [6:0]         immHigh;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [4:0]         immLow;
        logic [6:0]         opcode;
    } sFieldsT;

    typedef union packed {
        rFieldsT rFields;
        sFieldsT sFields;
    } instrWord;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPassB
    } aluOp;

endpackage

`default_nettype wire

//--- verilog/rvPipeCore_defines.svh
`ifndef RV_PIPE_CORE_DEFINES_SVH
`define RV_PIPE_CORE_DEFINES_SVH

`define XLEN        32
`define IADDR_W     10              // ROM word address
`define DADDR_W     10              // RAM word address
`define REG_AW      5

// Base opcodes of the supported subset
`define OP_REG      7'h33
`define OP_IMM      7'h13
`define OP_LOAD     7'h03
`define OP_STORE    7'h23
`define OP_LUI      7'h37

`define NOP_INSTR   32'h0000_0013   // addi x0, x0, 0
`define GPIO_ADDR   10'd0

// Operand source selects
`define FWD_RF      2'd0
`define FWD_MEM     2'd1
`define FWD_WB      2'd2

`endif
